// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -j 0
TOP        ?= mem_subsys_tb
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := === PASS ===

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/bus_pkg.sv ====
package bus_pkg;

  typedef logic [31:0] bus_adr_t;
  typedef logic [31:0] bus_dat_t;
  typedef logic [3:0]  bus_sel_t;

  // sel[3] is the most significant byte lane, bits 31:24
  localparam bus_sel_t SEL_ALL = 4'b1111;

  // master to target, held until ack
  typedef struct packed {
    logic     cyc;
    logic     we;
    bus_adr_t adr;
    bus_sel_t sel;
    bus_dat_t dat;
  } bus_req_t;

  // target to master
  typedef struct packed {
    logic     ack;  // single cycle pulse
    bus_dat_t dat;  // read data, valid with ack
  } bus_rsp_t;

endpackage

// ==== design/cpu_pkg.sv ====
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [63:0] ir_t;
  typedef logic [3:0]  reg_addr_t;
  typedef logic [3:0]  bank_t;

  // instruction class, ir[31:28]
  typedef enum logic [3:0] {
    T_INH    = 4'h0,
    T_PUSH   = 4'h1,
    T_POP    = 4'h2,
    T_CMP    = 4'h3,
    T_MOV    = 4'h4,
    T_FPU    = 4'h5,
    T_FP     = 4'h6,
    T_ALU    = 4'h7,
    T_INT    = 4'h8,
    T_LDI    = 4'h9,
    T_LOAD   = 4'ha,
    T_STORE  = 4'hb,
    T_BRANCH = 4'hc,
    T_JUMP   = 4'hd
  } ir_type_e;

  // access size, low bits of the opcode field
  typedef enum logic [1:0] {
    SZ_WORD  = 2'h0,
    SZ_HALF  = 2'h1,
    SZ_BYTE  = 2'h2,
    SZ_WORD2 = 2'h3  // decoded as a word
  } mem_size_e;

  localparam reg_addr_t LINK_REG = 4'd7;  // return address on exception

  typedef struct packed {
    ir_t        ir;
    word_t      result;    // address or alu value
    word_t      reg_data;  // store data
    word_t      pc;
    logic       pc_set;
    logic [1:0] reg_write;
    bank_t      bank;
    logic       halt;
    logic       exc;
  } pipe_in_t;

  typedef struct packed {
    ir_t        ir;
    word_t      result;
    word_t      pc;
    logic       pc_set;
    logic [1:0] reg_write;
    reg_addr_t  reg_write_addr;
    bank_t      bank;
    logic       halt;
    logic       exc;
  } pipe_out_t;

  function automatic ir_type_e get_type(ir_t ir);
    return ir_type_e'(ir[31:28]);
  endfunction

  function automatic mem_size_e get_size(ir_t ir);
    return mem_size_e'(ir[25:24]);
  endfunction

endpackage

// ==== design/data_ram.sv ====
module data_ram #(
  parameter int ACK_DELAY = 1,
  parameter int MEM_WORDS = 256
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  bus_pkg::bus_req_t req_i,
  output bus_pkg::bus_rsp_t rsp_o
);

  localparam int ADR_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CNT_W = (ACK_DELAY > 0) ? $clog2(ACK_DELAY + 1) : 1;

  bus_pkg::bus_dat_t mem [MEM_WORDS];
  bus_pkg::bus_dat_t rd_dat_q;
  logic [CNT_W-1:0]  wait_cnt;
  logic              ack_q;
  logic [ADR_W-1:0]  word_idx;
  logic              ack_now;  // this edge completes the cycle

  assign word_idx = req_i.adr[ADR_W+1:2];
  assign ack_now  = req_i.cyc && !ack_q && (wait_cnt == CNT_W'(ACK_DELAY));

  initial
  begin
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = '0;
  end

  // wait states, restart after every ack
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wait_cnt <= '0;
      ack_q    <= 1'b0;
    end
    else if (ack_q || !req_i.cyc)
    begin
      wait_cnt <= '0;
      ack_q    <= 1'b0;
    end
    else if (ack_now)
    begin
      wait_cnt <= '0;
      ack_q    <= 1'b1;
    end
    else
      wait_cnt <= wait_cnt + 1'b1;
  end

  // array access on the ack edge, sel[3] is bits 31:24
  always_ff @(posedge clk_i)
  begin
    if (ack_now)
    begin
      if (req_i.we)
      begin
        for (int b = 0; b < 4; b++)
          if (req_i.sel[b])
            mem[word_idx][8*b +: 8] <= req_i.dat[8*b +: 8];
      end
      else
        rd_dat_q <= mem[word_idx];
    end
  end

  assign rsp_o = '{ack: ack_q, dat: rd_dat_q};

endmodule

// ==== design/exc_vector.sv ====
module exc_vector (
  input  cpu_pkg::pipe_in_t  pipe_i,
  input  cpu_pkg::word_t     bus_dat_i,
  output bus_pkg::bus_req_t  req_o,
  output cpu_pkg::pipe_out_t redirect_o
);

  // vector fetch is always a full word read
  always_comb
  begin
    req_o.cyc = pipe_i.exc;
    req_o.we  = 1'b0;
    req_o.adr = pipe_i.result;  // vector address from execute
    req_o.sel = bus_pkg::SEL_ALL;
    req_o.dat = '0;
  end

  always_comb
  begin
    redirect_o.ir             = pipe_i.ir;
    redirect_o.bank           = pipe_i.bank;
    redirect_o.halt           = pipe_i.halt;
    redirect_o.exc            = pipe_i.exc;
    redirect_o.pc             = bus_dat_i;  // handler entry
    redirect_o.pc_set         = 1'b1;
    redirect_o.result         = pipe_i.pc + 32'd4;  // return address
    redirect_o.reg_write_addr = cpu_pkg::LINK_REG;
    redirect_o.reg_write      = 2'b11;  // full 32-bit write
  end

endmodule

// ==== design/mem_access.sv ====
module mem_access (
  input  cpu_pkg::pipe_in_t pipe_i,
  input  cpu_pkg::word_t    bus_dat_i,
  output bus_pkg::bus_req_t req_o,
  output cpu_pkg::word_t    load_data_o
);

  cpu_pkg::ir_type_e  ir_type;
  cpu_pkg::mem_size_e ir_size;
  logic [1:0]         offs;
  logic [4:0]         byte_sh;  // bit position of the addressed byte

  assign ir_type = cpu_pkg::get_type(pipe_i.ir);
  assign ir_size = cpu_pkg::get_size(pipe_i.ir);
  assign offs    = pipe_i.result[1:0];
  assign byte_sh = {~offs, 3'b000};  // offset 0 sits in bits 31:24

  always_comb
  begin
    req_o.cyc = (ir_type == cpu_pkg::T_LOAD) || (ir_type == cpu_pkg::T_STORE);
    req_o.we  = (ir_type == cpu_pkg::T_STORE);
    req_o.adr = pipe_i.result;
    case (ir_size)
      cpu_pkg::SZ_HALF:
      begin
        req_o.sel = offs[1] ? 4'b0011 : 4'b1100;
        req_o.dat = {2{pipe_i.reg_data[15:0]}};  // same half in both lanes
      end
      cpu_pkg::SZ_BYTE:
      begin
        req_o.sel = 4'b1000 >> offs;
        req_o.dat = {4{pipe_i.reg_data[7:0]}};
      end
      default:
      begin
        req_o.sel = bus_pkg::SEL_ALL;  // word and alternate word
        req_o.dat = pipe_i.reg_data;
      end
    endcase
  end

  // pick the addressed lanes, shift down, zero extend
  always_comb
  begin
    case (ir_size)
      cpu_pkg::SZ_HALF:
        load_data_o = {16'h0, offs[1] ? bus_dat_i[15:0] : bus_dat_i[31:16]};
      cpu_pkg::SZ_BYTE:
        load_data_o = {24'h0, bus_dat_i[byte_sh +: 8]};
      default:
        load_data_o = bus_dat_i;
    endcase
  end

endmodule

// ==== design/mem_stage.sv ====
module mem_stage (
  input  logic               clk_i,
  input  logic               rst_i,
  input  cpu_pkg::pipe_in_t  pipe_i,
  input  logic               stall_i,
  output logic               stall_o,
  output cpu_pkg::pipe_out_t pipe_o,
  output bus_pkg::bus_req_t  bus_req_o,
  input  bus_pkg::bus_rsp_t  bus_rsp_i
);

  bus_pkg::bus_req_t  ls_req;
  bus_pkg::bus_req_t  exc_req;
  cpu_pkg::word_t     load_data;
  cpu_pkg::pipe_out_t redirect;
  cpu_pkg::pipe_out_t pipe_next;
  logic               is_load;

  mem_access u_mem_access (
    .pipe_i      (pipe_i),
    .bus_dat_i   (bus_rsp_i.dat),
    .req_o       (ls_req),
    .load_data_o (load_data)
  );

  exc_vector u_exc_vector (
    .pipe_i     (pipe_i),
    .bus_dat_i  (bus_rsp_i.dat),
    .req_o      (exc_req),
    .redirect_o (redirect)
  );

  assign is_load = (cpu_pkg::get_type(pipe_i.ir) == cpu_pkg::T_LOAD);

  // exception entry takes the bus over any load or store
  assign bus_req_o = pipe_i.exc ? exc_req : ls_req;

  // wait here until the target answers
  assign stall_o = bus_req_o.cyc && !bus_rsp_i.ack;

  always_comb
  begin
    pipe_next.ir             = pipe_i.ir;
    pipe_next.result         = pipe_i.result;
    pipe_next.pc             = pipe_i.pc;
    pipe_next.pc_set         = pipe_i.pc_set;
    pipe_next.reg_write      = pipe_i.reg_write;
    pipe_next.reg_write_addr = pipe_i.ir[23:20];  // destination field
    pipe_next.bank           = pipe_i.bank;
    pipe_next.halt           = pipe_i.halt;
    pipe_next.exc            = pipe_i.exc;
    if (pipe_i.exc)
      pipe_next = redirect;
    else if (is_load)
      pipe_next.result = load_data;  // aligned during the ack cycle
  end

  // write-back register, frozen by either stall
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      pipe_o <= '0;
    else if (!stall_i && !stall_o)
      pipe_o <= pipe_next;
  end

endmodule

// ==== design/mem_subsys_top.sv ====
module mem_subsys_top #(
  parameter int ACK_DELAY = 1,
  parameter int MEM_WORDS = 256
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  cpu_pkg::pipe_in_t  pipe_i,
  input  logic               stall_i,
  output logic               stall_o,
  output cpu_pkg::pipe_out_t pipe_o
);

  bus_pkg::bus_req_t bus_req;  // stage to memory
  bus_pkg::bus_rsp_t bus_rsp;  // memory to stage

  mem_stage u_mem_stage (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .pipe_i    (pipe_i),
    .stall_i   (stall_i),
    .stall_o   (stall_o),
    .pipe_o    (pipe_o),
    .bus_req_o (bus_req),
    .bus_rsp_i (bus_rsp)
  );

  data_ram #(
    .ACK_DELAY (ACK_DELAY),
    .MEM_WORDS (MEM_WORDS)
  ) u_data_ram (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (bus_req),
    .rsp_o (bus_rsp)
  );

endmodule

// ==== filelist.f ====
design/cpu_pkg.sv
design/bus_pkg.sv
design/mem_access.sv
design/exc_vector.sv
design/mem_stage.sv
design/data_ram.sv
design/mem_subsys_top.sv
verif/tb_clock.sv
verif/mem_checker.sv
verif/mem_subsys_tb.sv

// ==== verif/mem_checker.sv ====
module mem_checker (
  input  logic               clk_i,
  input  logic               rst_i,
  input  cpu_pkg::pipe_in_t  pipe_in_i,
  input  logic               stall_in_i,
  input  logic               stall_out_i,
  input  cpu_pkg::pipe_out_t pipe_out_i,
  input  cpu_pkg::pipe_out_t exp_i,
  output int                 err_count_o,
  output int                 check_count_o
);

  cpu_pkg::pipe_out_t exp_q [$];
  cpu_pkg::pipe_out_t exp_item;
  cpu_pkg::pipe_out_t held;  // pipe_o as seen on the last falling edge
  logic               took;
  logic               is_mem;
  logic               stall_seen;

  task automatic compare_field(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
    if (exp_v !== act_v)
    begin
      $display("[ERROR] pipe_o.%s expected %0h actual %0h", name, exp_v, act_v);
      err_count_o++;
    end
  endtask

  task automatic compare_item(input cpu_pkg::pipe_out_t e, input cpu_pkg::pipe_out_t a);
    compare_field("ir", e.ir, a.ir);
    compare_field("result", 64'(e.result), 64'(a.result));
    compare_field("pc", 64'(e.pc), 64'(a.pc));
    compare_field("pc_set", 64'(e.pc_set), 64'(a.pc_set));
    compare_field("reg_write", 64'(e.reg_write), 64'(a.reg_write));
    compare_field("reg_write_addr", 64'(e.reg_write_addr), 64'(a.reg_write_addr));
    compare_field("bank", 64'(e.bank), 64'(a.bank));
    compare_field("halt", 64'(e.halt), 64'(a.halt));
    compare_field("exc", 64'(e.exc), 64'(a.exc));
    check_count_o++;
  endtask

  initial
  begin
    err_count_o   = 0;
    check_count_o = 0;
    stall_seen    = 1'b0;
    took          = 1'b0;
    held          = '0;
    forever
    begin
      @(posedge clk_i);
      // values seen here are the ones the stage register samples
      took   = !rst_i && !stall_in_i && !stall_out_i;
      is_mem = pipe_in_i.exc || (pipe_in_i.ir[31:28] == cpu_pkg::T_LOAD) ||
               (pipe_in_i.ir[31:28] == cpu_pkg::T_STORE);
      if (!rst_i)
      begin
        if (is_mem && stall_out_i)
          stall_seen = 1'b1;
        if (!is_mem && stall_out_i)
        begin
          $display("[ERROR] stall_o expected %0h actual %0h for a non-memory item at %0t",
                   1'b0, stall_out_i, $time);
          err_count_o++;
        end
        if (took)
        begin
          if (is_mem && !stall_seen)
          begin
            $display("memory item finished without stall_o at %0t", $time);
            err_count_o++;
          end
          stall_seen = 1'b0;
          exp_q.push_back(exp_i);
        end
      end

      @(negedge clk_i);
      if (took)
      begin
        exp_item = exp_q.pop_front();
        compare_item(exp_item, pipe_out_i);
      end
      else if (!rst_i && (pipe_out_i !== held))
      begin
        $display("pipe_o changed while the stage was stalled at %0t", $time);
        err_count_o++;
      end
      held = pipe_out_i;
    end
  end

endmodule

// ==== verif/mem_subsys_tb.sv ====
module mem_subsys_tb;

  localparam int ACK_DELAY    = 1;
  localparam int MEM_WORDS    = 256;
  localparam int ADR_W        = $clog2(MEM_WORDS);
  localparam int RESET_CYCLES = 10;
  localparam int NUM_ITEMS    = 300;  // flush item included
  localparam int TIMEOUT      = NUM_ITEMS * (ACK_DELAY + 4) + RESET_CYCLES;

  logic               clk;
  logic               rst;
  logic               stall_in;
  logic               stall_out;
  logic               accepted;  // stage register took pipe_in on the last edge
  cpu_pkg::pipe_in_t  pipe_in;
  cpu_pkg::pipe_out_t pipe_out;
  cpu_pkg::pipe_out_t exp_out;   // expected write-back of the item on pipe_in
  int                 err_count;
  int                 check_count;
  int                 tb_errors;
  int                 cycles;
  cpu_pkg::word_t     shadow [MEM_WORDS];
  cpu_pkg::pipe_in_t  items [$];

  tb_clock #(.PERIOD(4)) u_clock (.clk_o(clk));

  mem_subsys_top #(
    .ACK_DELAY (ACK_DELAY),
    .MEM_WORDS (MEM_WORDS)
  ) dut_i (
    .clk_i   (clk),
    .rst_i   (rst),
    .pipe_i  (pipe_in),
    .stall_i (stall_in),
    .stall_o (stall_out),
    .pipe_o  (pipe_out)
  );

  mem_checker u_checker (
    .clk_i         (clk),
    .rst_i         (rst),
    .pipe_in_i     (pipe_in),
    .stall_in_i    (stall_in),
    .stall_out_i   (stall_out),
    .pipe_out_i    (pipe_out),
    .exp_i         (exp_out),
    .err_count_o   (err_count),
    .check_count_o (check_count)
  );

  function automatic cpu_pkg::pipe_in_t make_item(input logic [3:0] ty, input logic [1:0] sz,
                                                  input cpu_pkg::word_t adr,
                                                  input cpu_pkg::word_t dat, input logic exc);
    cpu_pkg::pipe_in_t p;
    p.ir        = {$urandom, $urandom};
    p.ir[31:28] = ty;
    p.ir[25:24] = sz;
    p.result    = adr;
    p.reg_data  = dat;
    p.pc        = $urandom & 32'hffff_fffc;
    p.pc_set    = 1'($urandom);
    p.reg_write = 2'($urandom);
    p.bank      = 4'($urandom);
    p.halt      = 1'($urandom);
    p.exc       = exc;
    return p;
  endfunction

  // expected write-back with offset 0 in bits 31:24
  function automatic cpu_pkg::pipe_out_t expect_result(input cpu_pkg::pipe_in_t p);
    cpu_pkg::pipe_out_t e;
    cpu_pkg::word_t     w;
    logic [1:0]         off;
    w                = shadow[p.result[ADR_W+1:2]];
    off              = p.result[1:0];
    e.ir             = p.ir;
    e.result         = p.result;
    e.pc             = p.pc;
    e.pc_set         = p.pc_set;
    e.reg_write      = p.reg_write;
    e.reg_write_addr = p.ir[23:20];
    e.bank           = p.bank;
    e.halt           = p.halt;
    e.exc            = p.exc;
    if (p.exc)
    begin
      e.pc             = w;  // vector word
      e.pc_set         = 1'b1;
      e.result         = p.pc + 32'd4;
      e.reg_write_addr = cpu_pkg::LINK_REG;
      e.reg_write      = 2'b11;
    end
    else if (p.ir[31:28] == cpu_pkg::T_LOAD)
    begin
      case (p.ir[25:24])
        cpu_pkg::SZ_HALF:
          e.result = off[1] ? {16'h0, w[15:0]} : {16'h0, w[31:16]};
        cpu_pkg::SZ_BYTE:
          case (off)
            2'd0: e.result = {24'h0, w[31:24]};
            2'd1: e.result = {24'h0, w[23:16]};
            2'd2: e.result = {24'h0, w[15:8]};
            default: e.result = {24'h0, w[7:0]};
          endcase
        default:
          e.result = w;
      endcase
    end
    return e;
  endfunction

  task automatic apply_store(input cpu_pkg::pipe_in_t p);
    logic [ADR_W-1:0] idx;
    logic [1:0]       off;
    idx = p.result[ADR_W+1:2];
    off = p.result[1:0];
    case (p.ir[25:24])
      cpu_pkg::SZ_HALF:
        if (off[1])
          shadow[idx][15:0] = p.reg_data[15:0];
        else
          shadow[idx][31:16] = p.reg_data[15:0];
      cpu_pkg::SZ_BYTE:
        case (off)
          2'd0: shadow[idx][31:24] = p.reg_data[7:0];
          2'd1: shadow[idx][23:16] = p.reg_data[7:0];
          2'd2: shadow[idx][15:8]  = p.reg_data[7:0];
          default: shadow[idx][7:0] = p.reg_data[7:0];
        endcase
      default:
        shadow[idx] = p.reg_data;
    endcase
  endtask

  task automatic build_items();
    cpu_pkg::word_t adr;
    logic [3:0]     ty;
    int             pick;
    items.push_back(make_item(cpu_pkg::T_STORE, cpu_pkg::SZ_WORD, 32'h40, 32'hdead_beef, 1'b0));
    items.push_back(make_item(cpu_pkg::T_LOAD, cpu_pkg::SZ_WORD, 32'h40, '0, 1'b0));
    for (int off = 0; off < 4; off++)
    begin
      adr = 32'h80 + 32'(off);
      items.push_back(make_item(cpu_pkg::T_STORE, cpu_pkg::SZ_BYTE, adr, $urandom, 1'b0));
      items.push_back(make_item(cpu_pkg::T_LOAD, cpu_pkg::SZ_BYTE, adr, '0, 1'b0));
      items.push_back(make_item(cpu_pkg::T_LOAD, cpu_pkg::SZ_WORD, 32'h80, '0, 1'b0));
      adr = 32'h90 + 32'(off);
      items.push_back(make_item(cpu_pkg::T_STORE, cpu_pkg::SZ_HALF, adr, $urandom, 1'b0));
      items.push_back(make_item(cpu_pkg::T_LOAD, cpu_pkg::SZ_HALF, adr, '0, 1'b0));
      items.push_back(make_item(cpu_pkg::T_LOAD, cpu_pkg::SZ_WORD, 32'h90, '0, 1'b0));
    end
    items.push_back(make_item(cpu_pkg::T_ALU, cpu_pkg::SZ_WORD, $urandom, $urandom, 1'b0));
    items.push_back(make_item(cpu_pkg::T_MOV, cpu_pkg::SZ_BYTE, $urandom, $urandom, 1'b0));
    items.push_back(make_item(cpu_pkg::T_STORE, cpu_pkg::SZ_WORD, 32'h100, 32'h2000, 1'b0));
    items.push_back(make_item(cpu_pkg::T_INH, cpu_pkg::SZ_WORD, 32'h100, '0, 1'b1));
    while (items.size() < NUM_ITEMS - 1)
    begin
      pick = int'($urandom % 8);
      adr  = $urandom % 256;  // small window so loads hit earlier stores
      ty   = 4'($urandom % 14);
      case (pick)
        0, 1: items.push_back(make_item(cpu_pkg::T_STORE, 2'($urandom), adr, $urandom, 1'b0));
        2, 3: items.push_back(make_item(cpu_pkg::T_LOAD, 2'($urandom), adr, $urandom, 1'b0));
        4: items.push_back(make_item(ty, 2'($urandom), adr & 32'hfc, $urandom, 1'b1));
        default:
        begin
          if ((ty == cpu_pkg::T_LOAD) || (ty == cpu_pkg::T_STORE))
            ty = cpu_pkg::T_ALU;
          items.push_back(make_item(ty, 2'($urandom), $urandom, $urandom, 1'b0));
        end
      endcase
    end
    items.push_back('0);  // empty item flushes the stage
  endtask

  task automatic present_item(input cpu_pkg::pipe_in_t p);
    exp_out = expect_result(p);
    pipe_in = p;
    if (!p.exc && (p.ir[31:28] == cpu_pkg::T_STORE))
      apply_store(p);
  endtask

  task automatic print_summary();
    $display("checks %0d, checker errors %0d, testbench errors %0d, cycles %0d",
             check_count, err_count, tb_errors, cycles);
  endtask

  always @(posedge clk)
  begin
    accepted <= !rst && !stall_in && !stall_out;
    cycles   <= cycles + 1;
    if (cycles == TIMEOUT)
    begin
      $display("run stopped after %0d cycles, the test hung", cycles);
      print_summary();
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial
  begin
    void'($urandom(32'h58ba_c88b));
    rst       = 1'b1;
    stall_in  = 1'b0;
    pipe_in   = '0;
    exp_out   = '0;
    tb_errors = 0;
    cycles    = 0;
    for (int i = 0; i < MEM_WORDS; i++)
      shadow[i] = '0;
    build_items();
    repeat (RESET_CYCLES) @(negedge clk);
    if ((pipe_out.pc_set !== 1'b0) || (pipe_out.reg_write !== 2'b00) ||
        (pipe_out.halt !== 1'b0) || (pipe_out.exc !== 1'b0))
    begin
      $display("[ERROR] pipe_o.{pc_set,reg_write,halt,exc} expected 0,0,0,0 actual %0h,%0h,%0h,%0h",
               pipe_out.pc_set, pipe_out.reg_write, pipe_out.halt, pipe_out.exc);
      tb_errors++;
    end
    rst = 1'b0;
    for (int n = 0; n < items.size(); n++)
    begin
      present_item(items[n]);
      do
      begin
        @(negedge clk);
        stall_in = (($urandom % 8) == 0);  // back-pressure about 1 in 8
      end
      while (!accepted);
    end
    stall_in = 1'b1;  // hold the last item on pipe_o
    repeat (3) @(negedge clk);
    print_summary();
    if ((err_count == 0) && (tb_errors == 0))
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== verif/tb_clock.sv ====
module tb_clock #(
  parameter int PERIOD = 4
) (
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;  // free running
  end

endmodule
